// ==== src.f ====
mem_pkg.sv
axi_lite_if.sv
sram_slave.sv
axi_arbiter.sv
ifetch_port.sv
lsu_port.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module tb_mem_subsys -o sim
	obj_dir/sim | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_mem_subsys.sv ====
`timescale 1ns/10ps

module tb_mem_subsys;

	localparam int RESET_CYCLES = 16;
	localparam int FILL_WORDS = 32;
	localparam int RAND_PAIRS = 100;
	localparam int BYTE_CHECKS = 8;
	localparam int FETCHES = 16;
	localparam int RANGE_OPS = 4;
	localparam int DUAL_PAIRS = 8;
	// one test per request issued
	localparam int N_TESTS = FILL_WORDS + 2 * RAND_PAIRS + 2 * BYTE_CHECKS + FETCHES
		+ RANGE_OPS + 2 * DUAL_PAIRS;
	localparam int DONE_LIMIT = 20;

	logic clk;
	logic rst;
	logic fetch_req;
	mem_pkg::addr_t fetch_pc;
	logic fetch_done;
	mem_pkg::inst_t fetch_inst;
	logic fetch_err;
	logic ls_req;
	logic ls_we;
	mem_pkg::size_t ls_size;
	logic ls_unsigned;
	mem_pkg::addr_t ls_addr;
	mem_pkg::data_t ls_wdata;
	logic ls_done;
	mem_pkg::data_t ls_rdata;
	logic ls_err;

	// byte addressed copy of the sram contents
	logic [7:0] shadow [mem_pkg::MEM_BYTES];
	logic [15:0] lfsr;
	int errors;

	// expected results, handed from the stimulus to the compare process
	logic ls_busy;
	logic ls_is_load;
	mem_pkg::data_t exp_ls_data;
	logic exp_ls_err;
	logic fetch_busy;
	mem_pkg::inst_t exp_inst;
	logic exp_fetch_err;
	int ls_done_cnt;
	int fetch_done_cnt;
	int ls_mark;
	int fetch_mark;

	initial clk = 1'b0;
	always #50 clk = ~clk;

	mem_subsys_top dut0 (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_pc(fetch_pc),
		.fetch_done(fetch_done),
		.fetch_inst(fetch_inst),
		.fetch_err(fetch_err),
		.ls_req(ls_req),
		.ls_we(ls_we),
		.ls_size(ls_size),
		.ls_unsigned(ls_unsigned),
		.ls_addr(ls_addr),
		.ls_wdata(ls_wdata),
		.ls_done(ls_done),
		.ls_rdata(ls_rdata),
		.ls_err(ls_err)
	);

	// 16 bit fibonacci lfsr, taps 16 14 13 11, one step per bit
	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[62:0], fb};
		end
		return v;
	endfunction

	// naturally aligned byte offset inside a word
	function automatic logic [2:0] rand_offset(input mem_pkg::size_t size);
		logic [2:0] off;
		off = 3'(take_bits(3));
		off = off & (3'b111 << size);
		return off;
	endfunction

	// random aligned address in the filled region
	function automatic mem_pkg::addr_t rand_addr(input mem_pkg::size_t size);
		logic [4:0] word;
		word = 5'(take_bits(5));
		return {24'd0, word, rand_offset(size)};
	endfunction

	// little endian gather from the shadow, then zero or sign extension
	function automatic mem_pkg::data_t ref_load(input mem_pkg::addr_t addr,
			input mem_pkg::size_t size, input logic uns);
		mem_pkg::data_t v;
		logic [10:0] idx;
		int nbytes;
		nbytes = 1 << size;
		v = '0;
		for (int i = 7; i >= 0; i--) begin
			if (i < nbytes) begin
				idx = addr[10:0] + 11'(i);
				v = {v[55:0], shadow[idx]};
			end
		end
		case (size)
			mem_pkg::SIZE_B: v = uns ? {56'd0, v[7:0]} : 64'($signed(v[7:0]));
			mem_pkg::SIZE_H: v = uns ? {48'd0, v[15:0]} : 64'($signed(v[15:0]));
			mem_pkg::SIZE_W: v = uns ? {32'd0, v[31:0]} : 64'($signed(v[31:0]));
			default: v = v;
		endcase
		return v;
	endfunction

	// instruction is the 4 bytes at pc, bits 1:0 ignored
	function automatic mem_pkg::inst_t ref_fetch(input mem_pkg::addr_t pc);
		logic [10:0] base;
		base = {pc[10:2], 2'b00};
		return {shadow[base + 11'd3], shadow[base + 11'd2], shadow[base + 11'd1], shadow[base]};
	endfunction

	task automatic arm_store(input mem_pkg::addr_t addr, input mem_pkg::size_t size,
			input mem_pkg::data_t data);
		mem_pkg::data_t d;
		logic [10:0] idx;
		int nbytes;
		d = data;
		nbytes = 1 << size;
		ls_we = 1'b1;
		ls_size = size;
		ls_unsigned = 1'b0;
		ls_addr = addr;
		ls_wdata = data;
		ls_req = 1'b1;
		// dropped by the sram when out of range
		if (addr < mem_pkg::MEM_BYTES) begin
			for (int i = 0; i < nbytes; i++) begin
				idx = addr[10:0] + 11'(i);
				shadow[idx] = d[7:0];
				d = d >> 8;
			end
		end
		ls_is_load = 1'b0;
		exp_ls_err = (addr >= mem_pkg::MEM_BYTES);
		ls_mark = ls_done_cnt;
		ls_busy = 1'b1;
	endtask

	task automatic arm_load(input mem_pkg::addr_t addr, input mem_pkg::size_t size,
			input logic uns);
		ls_we = 1'b0;
		ls_size = size;
		ls_unsigned = uns;
		ls_addr = addr;
		ls_wdata = '0;
		ls_req = 1'b1;
		ls_is_load = 1'b1;
		if (addr < mem_pkg::MEM_BYTES) begin
			exp_ls_data = ref_load(addr, size, uns);
			exp_ls_err = 1'b0;
		end else begin
			exp_ls_data = '0;
			exp_ls_err = 1'b1;
		end
		ls_mark = ls_done_cnt;
		ls_busy = 1'b1;
	endtask

	task automatic arm_fetch(input mem_pkg::addr_t pc);
		fetch_pc = pc;
		fetch_req = 1'b1;
		if (pc < mem_pkg::MEM_BYTES) begin
			exp_inst = ref_fetch(pc);
			exp_fetch_err = 1'b0;
		end else begin
			exp_inst = '0;
			exp_fetch_err = 1'b1;
		end
		fetch_mark = fetch_done_cnt;
		fetch_busy = 1'b1;
	endtask

	// requests are one cycle pulses
	task automatic release_reqs();
		@(negedge clk);
		fetch_req = 1'b0;
		ls_req = 1'b0;
	endtask

	task automatic wait_ls();
		int n;
		n = 0;
		while (ls_done_cnt == ls_mark && n < DONE_LIMIT) begin
			@(posedge clk);
			n++;
		end
		assert (ls_done_cnt != ls_mark) else begin
			errors++;
			$display("load/store at %h did not finish within %0d cycles", ls_addr, DONE_LIMIT);
		end
		@(negedge clk);
	endtask

	task automatic wait_fetch();
		int n;
		n = 0;
		while (fetch_done_cnt == fetch_mark && n < DONE_LIMIT) begin
			@(posedge clk);
			n++;
		end
		assert (fetch_done_cnt != fetch_mark) else begin
			errors++;
			$display("fetch at %h did not finish within %0d cycles", fetch_pc, DONE_LIMIT);
		end
		@(negedge clk);
	endtask

	task automatic do_store(input mem_pkg::addr_t addr, input mem_pkg::size_t size,
			input mem_pkg::data_t data);
		arm_store(addr, size, data);
		release_reqs();
		wait_ls();
	endtask

	task automatic do_load(input mem_pkg::addr_t addr, input mem_pkg::size_t size,
			input logic uns);
		arm_load(addr, size, uns);
		release_reqs();
		wait_ls();
	endtask

	task automatic do_fetch(input mem_pkg::addr_t pc);
		arm_fetch(pc);
		release_reqs();
		wait_fetch();
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!rst && ls_done) begin
			// also catches a second pulse for one request
			assert (ls_busy) else begin
				errors++;
				$display("ls_done pulsed with no load/store in flight");
			end
			assert (ls_err === exp_ls_err) else begin
				errors++;
				$display("Error: ls_err expected %h got %h at %h", exp_ls_err, ls_err, ls_addr);
			end
			if (ls_is_load) begin
				assert (ls_rdata === exp_ls_data) else begin
					errors++;
					$display("Error: ls_rdata expected %h got %h at %h",
						exp_ls_data, ls_rdata, ls_addr);
				end
			end
			ls_busy = 1'b0;
			ls_done_cnt++;
		end
		if (!rst && fetch_done) begin
			assert (fetch_busy) else begin
				errors++;
				$display("fetch_done pulsed with no fetch in flight");
			end
			assert (fetch_err === exp_fetch_err) else begin
				errors++;
				$display("Error: fetch_err expected %h got %h at %h",
					exp_fetch_err, fetch_err, fetch_pc);
			end
			assert (fetch_inst === exp_inst) else begin
				errors++;
				$display("Error: fetch_inst expected %h got %h at %h", exp_inst, fetch_inst, fetch_pc);
			end
			fetch_busy = 1'b0;
			fetch_done_cnt++;
		end
	end

	initial begin
		mem_pkg::addr_t a;
		mem_pkg::addr_t b;
		mem_pkg::size_t sz;
		mem_pkg::size_t lsz;
		logic uns;
		lfsr = 16'd24320;
		errors = 0;
		ls_busy = 1'b0;
		ls_is_load = 1'b0;
		exp_ls_data = '0;
		exp_ls_err = 1'b0;
		fetch_busy = 1'b0;
		exp_inst = '0;
		exp_fetch_err = 1'b0;
		ls_done_cnt = 0;
		fetch_done_cnt = 0;
		ls_mark = 0;
		fetch_mark = 0;
		rst = 1'b1;
		fetch_req = 1'b0;
		fetch_pc = '0;
		ls_req = 1'b0;
		ls_we = 1'b0;
		ls_size = '0;
		ls_unsigned = 1'b0;
		ls_addr = '0;
		ls_wdata = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// quiet after reset
		repeat (8) begin
			@(negedge clk);
			assert (!fetch_done && !ls_done) else begin
				errors++;
				$display("done pulse seen after reset before any request");
			end
		end

		// fill so every later read hits defined data
		for (int w = 0; w < FILL_WORDS; w++) begin
			do_store(32'(w * 8), mem_pkg::SIZE_D, take_bits(64));
		end

		// random store, then a load from the same word
		for (int k = 0; k < RAND_PAIRS; k++) begin
			sz = 2'(take_bits(2));
			a = rand_addr(sz);
			do_store(a, sz, take_bits(64));
			lsz = 2'(take_bits(2));
			uns = 1'(take_bits(1));
			b = {a[31:3], rand_offset(lsz)};
			do_load(b, lsz, uns);
		end

		// byte store must leave its neighbours alone
		for (int k = 0; k < BYTE_CHECKS; k++) begin
			a = rand_addr(mem_pkg::SIZE_B);
			do_store(a, mem_pkg::SIZE_B, take_bits(64));
			do_load({a[31:3], 3'b000}, mem_pkg::SIZE_D, 1'b0);
		end

		// alternate lower and upper instruction halves
		for (int k = 0; k < FETCHES; k++) begin
			a = rand_addr(mem_pkg::SIZE_W);
			a[2] = k[0];
			do_fetch(a);
		end

		// past the end, index bits alias word 2
		a = mem_pkg::MEM_BYTES + 32'h10;
		do_load(a, mem_pkg::SIZE_D, 1'b0);
		do_store(a, mem_pkg::SIZE_D, take_bits(64));
		do_fetch(a);
		do_load(32'h10, mem_pkg::SIZE_D, 1'b0);

		// fetch and load raised together, arbiter serialises them
		for (int k = 0; k < DUAL_PAIRS; k++) begin
			a = rand_addr(mem_pkg::SIZE_W);
			lsz = 2'(take_bits(2));
			uns = 1'(take_bits(1));
			b = rand_addr(lsz);
			arm_fetch(a);
			arm_load(b, lsz, uns);
			release_reqs();
			wait_fetch();
			wait_ls();
			repeat (4) @(negedge clk);
		end

		repeat (4) @(negedge clk);
		$display("run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// bound on the whole run
	initial begin
		#((N_TESTS * 20 + RESET_CYCLES + 16) * 100);
		$display("watchdog expired before the tests finished, %0d errors so far", errors);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top (
	input logic clk,
	input logic rst,
	// instruction fetch
	input logic fetch_req,
	input mem_pkg::addr_t fetch_pc,
	output logic fetch_done,
	output mem_pkg::inst_t fetch_inst,
	output logic fetch_err,
	// load/store
	input logic ls_req,
	input logic ls_we,
	input mem_pkg::size_t ls_size,
	input logic ls_unsigned,
	input mem_pkg::addr_t ls_addr,
	input mem_pkg::data_t ls_wdata,
	output logic ls_done,
	output mem_pkg::data_t ls_rdata,
	output logic ls_err
);

	// fetch side, load/store side, shared sram side
	axi_lite_if if_bus ();
	axi_lite_if ls_bus ();
	axi_lite_if mem_bus ();

	ifetch_port u_ifetch (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_pc(fetch_pc),
		.fetch_done(fetch_done),
		.fetch_inst(fetch_inst),
		.fetch_err(fetch_err),
		.bus(if_bus.master)
	);

	lsu_port u_lsu (
		.clk(clk),
		.rst(rst),
		.ls_req(ls_req),
		.ls_we(ls_we),
		.ls_size(ls_size),
		.ls_unsigned(ls_unsigned),
		.ls_addr(ls_addr),
		.ls_wdata(ls_wdata),
		.ls_done(ls_done),
		.ls_rdata(ls_rdata),
		.ls_err(ls_err),
		.bus(ls_bus.master)
	);

	// fetch is m0, load/store is m1
	axi_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.m0(if_bus.slave),
		.m1(ls_bus.slave),
		.s(mem_bus.master)
	);

	sram_slave u_sram (
		.clk(clk),
		.rst(rst),
		.bus(mem_bus.slave)
	);

endmodule

// ==== lsu_port.sv ====
`timescale 1ns/10ps

module lsu_port (
	input logic clk,
	input logic rst,
	input logic ls_req,
	input logic ls_we,
	input mem_pkg::size_t ls_size,
	input logic ls_unsigned,
	input mem_pkg::addr_t ls_addr,
	input mem_pkg::data_t ls_wdata,
	output logic ls_done,
	output mem_pkg::data_t ls_rdata,
	output logic ls_err,
	axi_lite_if.master bus
);

	typedef enum logic [1:0] {
		LS_IDLE,
		LS_RD_WAIT,
		LS_WR_WAIT,
		LS_DONE
	} ls_state_e;

	ls_state_e state;
	// address phase still waiting for its handshake
	logic pend;
	logic uns_q;
	mem_pkg::size_t size_q;
	mem_pkg::addr_t addr_q;
	mem_pkg::data_t wdata_q;
	logic [2:0] offset;
	mem_pkg::data_t lane_data;
	mem_pkg::strb_t lane_strb;
	mem_pkg::data_t shifted;
	mem_pkg::data_t load_val;
	logic ar_fire;
	logic aw_fire;
	logic r_fire;
	logic b_fire;

	assign offset = addr_q[2:0];
	assign ar_fire = bus.arvalid && bus.arready;
	assign aw_fire = bus.awvalid && bus.awready;
	assign r_fire = bus.rvalid && bus.rready;
	assign b_fire = bus.bvalid && bus.bready;

	// store data copied to every lane, strobe picks the live bytes
	always_comb begin
		case (size_q)
			mem_pkg::SIZE_B: begin
				lane_data = {8{wdata_q[7:0]}};
				lane_strb = 8'h01 << offset;
			end
			mem_pkg::SIZE_H: begin
				lane_data = {4{wdata_q[15:0]}};
				lane_strb = 8'h03 << offset;
			end
			mem_pkg::SIZE_W: begin
				lane_data = {2{wdata_q[31:0]}};
				lane_strb = 8'h0f << offset;
			end
			default: begin
				lane_data = wdata_q;
				lane_strb = {mem_pkg::LANES{1'b1}};
			end
		endcase
	end

	// load: byte offset down to lane 0, then size and extension
	always_comb begin
		shifted = bus.rdata >> {offset, 3'b000};
		case (size_q)
			mem_pkg::SIZE_B: load_val = {{56{shifted[7] & ~uns_q}}, shifted[7:0]};
			mem_pkg::SIZE_H: load_val = {{48{shifted[15] & ~uns_q}}, shifted[15:0]};
			mem_pkg::SIZE_W: load_val = {{32{shifted[31] & ~uns_q}}, shifted[31:0]};
			default: load_val = shifted;
		endcase
	end

	assign bus.arvalid = (state == LS_RD_WAIT) && pend;
	assign bus.araddr = {addr_q[31:3], 3'b000};
	assign bus.rready = (state == LS_RD_WAIT);
	assign bus.awvalid = (state == LS_WR_WAIT) && pend;
	assign bus.awaddr = {addr_q[31:3], 3'b000};
	assign bus.wvalid = bus.awvalid;
	assign bus.wdata = lane_data;
	assign bus.wstrb = lane_strb;
	assign bus.bready = (state == LS_WR_WAIT);
	assign ls_done = (state == LS_DONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LS_IDLE;
			pend <= 1'b0;
		end else begin
			case (state)
				LS_IDLE: begin
					if (ls_req) begin
						state <= ls_we ? LS_WR_WAIT : LS_RD_WAIT;
						pend <= 1'b1;
					end
				end
				LS_RD_WAIT: begin
					if (ar_fire) begin
						pend <= 1'b0;
					end
					if (r_fire) begin
						state <= LS_DONE;
					end
				end
				LS_WR_WAIT: begin
					if (aw_fire) begin
						pend <= 1'b0;
					end
					if (b_fire) begin
						state <= LS_DONE;
					end
				end
				// single cycle done pulse
				default: state <= LS_IDLE;
			endcase
		end
	end

	// request fields and results
	always_ff @(posedge clk) begin
		if (state == LS_IDLE && ls_req) begin
			size_q <= ls_size;
			uns_q <= ls_unsigned;
			addr_q <= ls_addr;
			wdata_q <= ls_wdata;
		end
		if (r_fire) begin
			ls_rdata <= load_val;
			ls_err <= (bus.rresp == mem_pkg::RESP_SLVERR);
		end
		if (b_fire) begin
			ls_err <= (bus.bresp == mem_pkg::RESP_SLVERR);
		end
	end

endmodule

// ==== ifetch_port.sv ====
`timescale 1ns/10ps

module ifetch_port (
	input logic clk,
	input logic rst,
	input logic fetch_req,
	input mem_pkg::addr_t fetch_pc,
	output logic fetch_done,
	output mem_pkg::inst_t fetch_inst,
	output logic fetch_err,
	axi_lite_if.master bus
);

	typedef enum logic [1:0] {
		F_IDLE,
		F_ADDR,
		F_RESP
	} fetch_state_e;

	fetch_state_e state;
	mem_pkg::addr_t pc_q;
	logic r_fire;

	assign r_fire = bus.rvalid && bus.rready;

	// read only, write channels stay quiet
	assign bus.awvalid = 1'b0;
	assign bus.awaddr = '0;
	assign bus.wvalid = 1'b0;
	assign bus.wdata = '0;
	assign bus.wstrb = '0;
	assign bus.bready = 1'b0;

	// doubleword aligned read of the pc
	assign bus.arvalid = (state == F_ADDR);
	assign bus.araddr = {pc_q[31:3], 3'b000};
	// always ready for read data
	assign bus.rready = 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= F_IDLE;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				// a request while busy is dropped
				F_IDLE: begin
					if (fetch_req) begin
						state <= F_ADDR;
					end
				end
				F_ADDR: begin
					if (bus.arready) begin
						state <= F_RESP;
					end
				end
				F_RESP: begin
					if (r_fire) begin
						state <= F_IDLE;
						fetch_done <= 1'b1;
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	// pc latch and instruction half select
	always_ff @(posedge clk) begin
		if (state == F_IDLE && fetch_req) begin
			pc_q <= fetch_pc;
		end
		if (state == F_RESP && r_fire) begin
			fetch_inst <= pc_q[2] ? bus.rdata[63:32] : bus.rdata[31:0];
			fetch_err <= (bus.rresp == mem_pkg::RESP_SLVERR);
		end
	end

endmodule

// ==== axi_arbiter.sv ====
`timescale 1ns/10ps

module axi_arbiter (
	input logic clk,
	input logic rst,
	axi_lite_if.slave m0,
	axi_lite_if.slave m1,
	axi_lite_if.master s
);

	logic pend0;
	logic pend1;
	logic locked;
	logic owner;
	logic sel;
	logic cur;
	logic active;
	logic g0;
	logic g1;
	logic rsp_done;

	// a master wants the bus when it raises either address valid
	assign pend0 = m0.arvalid || m0.awvalid;
	assign pend1 = m1.arvalid || m1.awvalid;

	// round robin, owner still names the master served last
	always_comb begin
		if (pend0 && pend1) begin
			sel = ~owner;
		end else begin
			sel = pend1;
		end
	end

	// locked keeps the owner, idle picks in the same cycle
	assign cur = locked ? owner : sel;
	assign active = locked || pend0 || pend1;
	assign g0 = active && !cur;
	assign g1 = active && cur;

	// transaction ends on the r or b handshake
	assign rsp_done = (s.rvalid && s.rready) || (s.bvalid && s.bready);

	always_ff @(posedge clk) begin
		if (rst) begin
			locked <= 1'b0;
			// m0 wins the first tie
			owner <= 1'b1;
		end else if (locked) begin
			if (rsp_done) begin
				locked <= 1'b0;
			end
		end else if (pend0 || pend1) begin
			locked <= 1'b1;
			owner <= sel;
		end
	end

	// request channels toward the slave
	assign s.arvalid = (g0 && m0.arvalid) || (g1 && m1.arvalid);
	assign s.araddr = cur ? m1.araddr : m0.araddr;
	assign s.awvalid = (g0 && m0.awvalid) || (g1 && m1.awvalid);
	assign s.awaddr = cur ? m1.awaddr : m0.awaddr;
	assign s.wvalid = (g0 && m0.wvalid) || (g1 && m1.wvalid);
	assign s.wdata = cur ? m1.wdata : m0.wdata;
	assign s.wstrb = cur ? m1.wstrb : m0.wstrb;
	assign s.rready = (g0 && m0.rready) || (g1 && m1.rready);
	assign s.bready = (g0 && m0.bready) || (g1 && m1.bready);

	// readies and response valids only reach the granted side
	assign m0.arready = g0 && s.arready;
	assign m0.awready = g0 && s.awready;
	assign m0.wready = g0 && s.wready;
	assign m0.rvalid = g0 && s.rvalid;
	assign m0.bvalid = g0 && s.bvalid;

	assign m1.arready = g1 && s.arready;
	assign m1.awready = g1 && s.awready;
	assign m1.wready = g1 && s.wready;
	assign m1.rvalid = g1 && s.rvalid;
	assign m1.bvalid = g1 && s.bvalid;

	// response payload is shared, qualified by the valids above
	assign m0.rdata = s.rdata;
	assign m0.rresp = s.rresp;
	assign m0.bresp = s.bresp;
	assign m1.rdata = s.rdata;
	assign m1.rresp = s.rresp;
	assign m1.bresp = s.bresp;

endmodule

// ==== sram_slave.sv ====
`timescale 1ns/10ps

module sram_slave (
	input logic clk,
	input logic rst,
	axi_lite_if.slave bus
);

	typedef enum logic {
		RD_IDLE,
		RD_RESP
	} rd_state_e;

	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} wr_state_e;

	// backing store, one entry per bus word
	mem_pkg::data_t mem [mem_pkg::MEM_WORDS];

	rd_state_e rd_state;
	wr_state_e wr_state;
	mem_pkg::word_idx_t rd_idx;
	mem_pkg::word_idx_t wr_idx;
	logic rd_ok;
	logic wr_ok;
	logic rd_fire;
	logic wr_fire;
	mem_pkg::data_t rd_data_q;
	mem_pkg::resp_t rd_resp_q;
	mem_pkg::resp_t wr_resp_q;

	// word select from the byte address
	assign rd_idx = bus.araddr[10:3];
	assign wr_idx = bus.awaddr[10:3];

	// range check against the array size
	assign rd_ok = (bus.araddr < mem_pkg::MEM_BYTES);
	assign wr_ok = (bus.awaddr < mem_pkg::MEM_BYTES);

	// read side takes a new address only when idle
	assign bus.arready = (rd_state == RD_IDLE);
	assign rd_fire = bus.arvalid && bus.arready;

	// aw and w must show up together, both accepted in one cycle
	assign bus.awready = (wr_state == WR_IDLE) && bus.awvalid && bus.wvalid;
	assign bus.wready = bus.awready;
	assign wr_fire = bus.awready;

	assign bus.rvalid = (rd_state == RD_RESP);
	assign bus.rdata = rd_data_q;
	assign bus.rresp = rd_resp_q;
	assign bus.bvalid = (wr_state == WR_RESP);
	assign bus.bresp = wr_resp_q;

	// read fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (rd_fire) begin
						rd_state <= RD_RESP;
					end
				end
				// hold the beat until the master takes it
				RD_RESP: begin
					if (bus.rready) begin
						rd_state <= RD_IDLE;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// read data captured at acceptance, zero when out of range
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rd_data_q <= rd_ok ? mem[rd_idx] : '0;
			rd_resp_q <= rd_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end
	end

	// write fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (wr_fire) begin
						wr_state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (bus.bready) begin
						wr_state <= WR_IDLE;
					end
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// array update at acceptance, merged lane by lane under wstrb
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			wr_resp_q <= wr_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
			// out of range writes are dropped
			if (wr_ok) begin
				for (int i = 0; i < mem_pkg::LANES; i++) begin
					if (bus.wstrb[i]) begin
						mem[wr_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
					end
				end
			end
		end
	end

endmodule

// ==== axi_lite_if.sv ====
`timescale 1ns/10ps

interface axi_lite_if;

	// read address channel
	logic arvalid;
	mem_pkg::addr_t araddr;
	logic arready;

	// read data channel
	logic rvalid;
	mem_pkg::data_t rdata;
	mem_pkg::resp_t rresp;
	logic rready;

	// write address channel
	logic awvalid;
	mem_pkg::addr_t awaddr;
	logic awready;

	// write data channel
	logic wvalid;
	mem_pkg::data_t wdata;
	mem_pkg::strb_t wstrb;
	logic wready;

	// write response channel
	logic bvalid;
	mem_pkg::resp_t bresp;
	logic bready;

	// requester side
	modport master (
		output arvalid, araddr, rready,
		output awvalid, awaddr, wvalid, wdata, wstrb, bready,
		input arready, rvalid, rdata, rresp,
		input awready, wready, bvalid, bresp
	);

	// responder side
	modport slave (
		input arvalid, araddr, rready,
		input awvalid, awaddr, wvalid, wdata, wstrb, bready,
		output arready, rvalid, rdata, rresp,
		output awready, wready, bvalid, bresp
	);

endinterface

// ==== mem_pkg.sv ====
package mem_pkg;

	// bus and address widths
	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0] strb_t;
	typedef logic [31:0] inst_t;

	// byte lanes per bus word
	localparam int LANES = 8;

	// axi response codes, only two are used here
	typedef logic [1:0] resp_t;
	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// access size, log2 of the byte count
	typedef logic [1:0] size_t;
	localparam size_t SIZE_B = 2'd0;
	localparam size_t SIZE_H = 2'd1;
	localparam size_t SIZE_W = 2'd2;
	localparam size_t SIZE_D = 2'd3;

	// sram geometry
	localparam int unsigned MEM_WORDS = 256;
	localparam int unsigned MEM_BYTES = MEM_WORDS * LANES;

	// word index, taken from address bits 10:3
	typedef logic [$clog2(MEM_WORDS)-1:0] word_idx_t;

endpackage
